/* logic/ahb_buf_pkg.sv */
// Endpoint buffer shared definitions
package ahb_buf_pkg;

  // **********************************************************
  // Widths and sizes
  // **********************************************************
  // AHB address and data buses
  localparam int ADDR_W = 7;
  localparam int DATA_W = 32;
  // Packet side moves one byte at a time
  localparam int BYTE_W = 8;
  localparam int BUS_BYTES = DATA_W / BYTE_W;
  // Buffer storage and pointers
  localparam int FIFO_DEPTH = 64;
  localparam int PTR_W = 6;
  // Occupancy runs from 0 up to and including 64
  localparam int OCC_W = 7;
  // Bus byte count, 1 to 4
  localparam int NB_W = 3;

  // Protocol status flags and their bit positions
  localparam int STAT_W = 5;
  localparam int STAT_RX_READY = 0;
  localparam int STAT_RX_ACTIVE = 1;
  localparam int STAT_RX_ERROR = 2;
  localparam int STAT_TX_ACTIVE = 3;
  localparam int STAT_TX_ERROR = 4;

  // **********************************************************
  // Address map
  // **********************************************************
  // 0 to 63 all reach the FIFO
  localparam logic [ADDR_W-1:0] ADDR_DATA_LAST = 7'd63;
  localparam logic [ADDR_W-1:0] ADDR_STATUS = 7'd64;
  localparam logic [ADDR_W-1:0] ADDR_OCC = 7'd68;
  localparam logic [ADDR_W-1:0] ADDR_TX_SIZE = 7'd72;
  // First undefined address
  localparam logic [ADDR_W-1:0] ADDR_END = 7'd76;

  // **********************************************************
  // Encodings
  // **********************************************************
  // AHB transfer type
  typedef enum logic [1:0] {IDLE = 2'b00, BUSY = 2'b01, NONSEQ = 2'b10, SEQ = 2'b11} htrans_e;

  // AHB transfer size
  typedef enum logic [2:0] {BYTE = 3'b000, HALF = 3'b001, WORD = 3'b010} hsize_e;

  // Slave response state
  typedef enum logic [1:0] {OKAY, ERR_FIRST, ERR_SECOND} slave_state_e;

  // Decoded access target
  typedef enum logic [2:0] {
    ACC_NONE, ACC_DATA, ACC_STATUS, ACC_OCC, ACC_TX_SIZE, ACC_ILLEGAL
  } access_e;

endpackage

/* logic/ahb_slave_port.sv */
// AHB-Lite slave front end
`timescale 1ns/100ps

module ahb_slave_port (
  input  logic                           tb_clk,
  input  logic                           rst_i,
  input  logic                           hsel_i,
  input  logic [ahb_buf_pkg::ADDR_W-1:0] haddr_i,
  input  ahb_buf_pkg::htrans_e           htrans_i,
  input  ahb_buf_pkg::hsize_e            hsize_i,
  input  logic                           hwrite_i,
  input  logic [ahb_buf_pkg::DATA_W-1:0] hwdata_i,
  output logic [ahb_buf_pkg::DATA_W-1:0] hrdata_o,
  output logic                           hresp_o,
  output logic                           hready_o,
  input  logic [ahb_buf_pkg::OCC_W-1:0]  occupancy_i,
  input  logic                           bus_push_stall_i,
  input  logic [ahb_buf_pkg::DATA_W-1:0] bus_pop_data_i,
  input  logic [ahb_buf_pkg::DATA_W-1:0] status_word_i,
  input  logic [ahb_buf_pkg::OCC_W-1:0]  tx_size_i,
  output logic                           bus_push_o,
  output logic                           bus_pop_o,
  output logic [ahb_buf_pkg::NB_W-1:0]   bus_nbytes_o,
  output logic [ahb_buf_pkg::DATA_W-1:0] bus_push_data_o,
  output logic                           reg_wr_o,
  output logic [ahb_buf_pkg::OCC_W-1:0]  reg_wdata_o
);
  import ahb_buf_pkg::*;

  // Address phase decode
  logic             addr_take;
  access_e          acc_d;
  logic [NB_W-1:0]  nbytes_d;
  logic [OCC_W-1:0] nbytes_ext;
  logic [OCC_W-1:0] occ_proj;
  logic             raw_hazard;
  logic             addr_illegal;
  logic             err_start;
  // Data phase state
  logic             dp_valid_q;
  access_e          dp_acc_q;
  logic             dp_write_q;
  logic [NB_W-1:0]  dp_nbytes_q;
  logic [OCC_W-1:0] dp_nbytes_ext;
  logic             raw_wait_q;
  logic             dp_exec;
  slave_state_e     state_q;
  slave_state_e     state_d;

  // **********************************************************
  // Address phase
  // **********************************************************
  // BUSY counts as IDLE
  assign addr_take = hsel_i && (htrans_i == NONSEQ || htrans_i == SEQ) && hready_o;

  // Target from address window
  always_comb begin
    acc_d = ACC_ILLEGAL;
    if (!addr_take) begin
      acc_d = ACC_NONE;
    end else if (haddr_i <= ADDR_DATA_LAST) begin
      acc_d = ACC_DATA;
    end else if (haddr_i < ADDR_OCC) begin
      acc_d = ACC_STATUS;
    end else if (haddr_i < ADDR_TX_SIZE) begin
      acc_d = ACC_OCC;
    end else if (haddr_i < ADDR_END) begin
      acc_d = ACC_TX_SIZE;
    end
  end

  // Byte count of the transfer
  always_comb begin
    case (hsize_i)
      BYTE:    nbytes_d = 3'd1;
      HALF:    nbytes_d = 3'd2;
      default: nbytes_d = 3'd4;
    endcase
  end

  assign nbytes_ext = OCC_W'(nbytes_d);
  assign dp_nbytes_ext = OCC_W'(dp_nbytes_q);

  // Occupancy once the current data phase has completed
  assign occ_proj = occupancy_i + (bus_push_o ? dp_nbytes_ext : '0)
                  - (bus_pop_o ? dp_nbytes_ext : '0);

  // Data read right behind a data write waits one cycle
  assign raw_hazard = (acc_d == ACC_DATA) && !hwrite_i && bus_push_o;

  // Legality rules
  always_comb begin
    addr_illegal = 1'b0;
    case (acc_d)
      ACC_ILLEGAL: addr_illegal = 1'b1;
      ACC_STATUS, ACC_OCC: addr_illegal = hwrite_i;
      ACC_DATA: begin
        if (hwrite_i) begin
          addr_illegal = nbytes_ext > (OCC_W'(FIFO_DEPTH) - occ_proj);
        end else begin
          // Hazard reads are checked after the wait state
          addr_illegal = !raw_hazard && (nbytes_ext > occ_proj);
        end
      end
      default: addr_illegal = 1'b0;
    endcase
  end

  // New error from decode or from the hazard recheck
  assign err_start = (addr_take && addr_illegal)
                   || (raw_wait_q && (dp_nbytes_ext > occupancy_i));

  // **********************************************************
  // Response FSM
  // **********************************************************
  always_comb begin
    case (state_q)
      ERR_FIRST: state_d = ERR_SECOND;
      default:   state_d = err_start ? ERR_FIRST : OKAY;
    endcase
  end

  assign hresp_o = (state_q != OKAY);
  // Low for ERROR first cycle, hazard wait and push stall
  assign hready_o = (state_q != ERR_FIRST) && !raw_wait_q && !bus_push_stall_i;

  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      state_q <= OKAY;
      dp_valid_q <= 1'b0;
      raw_wait_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (raw_wait_q) begin
        // Recheck done, drop the read if it failed
        raw_wait_q <= 1'b0;
        dp_valid_q <= !err_start;
      end else if (hready_o) begin
        dp_valid_q <= addr_take && !addr_illegal;
        raw_wait_q <= addr_take && !addr_illegal && raw_hazard;
      end
    end
  end

  // Transfer attributes for the data phase
  always_ff @(posedge tb_clk) begin
    if (addr_take) begin
      dp_acc_q <= acc_d;
      dp_write_q <= hwrite_i;
      dp_nbytes_q <= nbytes_d;
    end
  end

  // **********************************************************
  // Data phase
  // **********************************************************
  assign dp_exec = dp_valid_q && !raw_wait_q;

  assign bus_push_o = dp_exec && (dp_acc_q == ACC_DATA) && dp_write_q;
  assign bus_pop_o = dp_exec && (dp_acc_q == ACC_DATA) && !dp_write_q;
  assign bus_nbytes_o = dp_nbytes_q;
  assign bus_push_data_o = hwdata_i;

  // Size register takes the low bits only
  assign reg_wr_o = dp_exec && (dp_acc_q == ACC_TX_SIZE) && dp_write_q;
  assign reg_wdata_o = hwdata_i[OCC_W-1:0];

  // Read data return
  always_comb begin
    case (dp_acc_q)
      ACC_DATA:    hrdata_o = bus_pop_data_i;
      ACC_STATUS:  hrdata_o = status_word_i;
      ACC_OCC:     hrdata_o = DATA_W'(occupancy_i);
      ACC_TX_SIZE: hrdata_o = DATA_W'(tx_size_i);
      default:     hrdata_o = '0;
    endcase
  end

endmodule

/* logic/endpoint_regs.sv */
// Endpoint status and size registers
`timescale 1ns/100ps

module endpoint_regs (
  input  logic                           tb_clk,
  input  logic                           rst_i,
  // Protocol controller flags
  input  logic                           rx_data_ready_i,
  input  logic                           rx_transfer_active_i,
  input  logic                           rx_error_i,
  input  logic                           tx_transfer_active_i,
  input  logic                           tx_error_i,
  // Write port from the bus side
  input  logic                           reg_wr_i,
  input  logic [ahb_buf_pkg::OCC_W-1:0]  reg_wdata_i,
  // Current buffer fill
  input  logic [ahb_buf_pkg::OCC_W-1:0]  occupancy_i,
  output logic [ahb_buf_pkg::DATA_W-1:0] status_word_o,
  output logic [ahb_buf_pkg::OCC_W-1:0]  tx_size_o,
  output logic                           buffer_reserved_o
);
  import ahb_buf_pkg::*;

  // Sampled protocol flags
  logic [STAT_W-1:0] status_q;
  // Transmit packet size
  logic [OCC_W-1:0]  tx_size_q;
  // Host has not yet filled the packet
  logic              filling;
  logic              size_set;

  // **********************************************************
  // Status register
  // **********************************************************
  // One cycle of latency from the controller pins
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      status_q <= '0;
    end else begin
      status_q[STAT_RX_READY] <= rx_data_ready_i;
      status_q[STAT_RX_ACTIVE] <= rx_transfer_active_i;
      status_q[STAT_RX_ERROR] <= rx_error_i;
      status_q[STAT_TX_ACTIVE] <= tx_transfer_active_i;
      status_q[STAT_TX_ERROR] <= tx_error_i;
    end
  end

  // Upper bits read as zero
  assign status_word_o = DATA_W'(status_q);

  // **********************************************************
  // Transmit size register
  // **********************************************************
  // Loaded at the end of the write data phase
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      tx_size_q <= '0;
    end else if (reg_wr_i) begin
      tx_size_q <= reg_wdata_i;
    end
  end

  assign tx_size_o = tx_size_q;

  // **********************************************************
  // Buffer reservation
  // **********************************************************
  // Zero size means no packet pending
  assign size_set = (tx_size_q != '0);
  assign filling = (occupancy_i < tx_size_q);

  // Held while the host is still writing the packet
  assign buffer_reserved_o = size_set && filling;

endmodule

/* logic/packet_fifo.sv */
// Endpoint packet byte FIFO
`timescale 1ns/100ps

module packet_fifo (
  input  logic                           tb_clk,
  input  logic                           rst_i,
  input  logic                           clear_i,
  // Packet side
  input  logic                           store_rx_packet_data_i,
  input  logic [ahb_buf_pkg::BYTE_W-1:0] rx_packet_data_i,
  input  logic                           get_tx_packet_data_i,
  // Bus side
  input  logic                           bus_push_i,
  input  logic                           bus_pop_i,
  input  logic [ahb_buf_pkg::NB_W-1:0]   bus_nbytes_i,
  input  logic [ahb_buf_pkg::DATA_W-1:0] bus_push_data_i,
  output logic [ahb_buf_pkg::OCC_W-1:0]  occupancy_o,
  output logic [ahb_buf_pkg::DATA_W-1:0] bus_pop_data_o,
  output logic                           bus_push_stall_o,
  output logic [ahb_buf_pkg::BYTE_W-1:0] tx_packet_data_o
);
  import ahb_buf_pkg::*;

  // Byte storage
  logic [BYTE_W-1:0] mem [FIFO_DEPTH];
  // Circular pointers and fill count
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [OCC_W-1:0]  count_q;
  // Last byte handed to the packet side
  logic [BYTE_W-1:0] tx_data_q;
  // Per-cycle movement
  logic              push_en;
  logic [OCC_W-1:0]  wr_n;
  logic [OCC_W-1:0]  pop_n;
  logic              get_en;
  logic [OCC_W-1:0]  rd_n;
  logic [PTR_W-1:0]  get_ptr;

  // **********************************************************
  // Request arbitration
  // **********************************************************
  // Packet store wins, bus push retries next cycle
  assign bus_push_stall_o = bus_push_i && store_rx_packet_data_i;
  assign push_en = bus_push_i && !store_rx_packet_data_i;

  // Bytes entering this cycle
  assign wr_n = store_rx_packet_data_i ? OCC_W'(1)
              : (push_en ? OCC_W'(bus_nbytes_i) : '0);

  // Bus pop takes the oldest bytes first
  assign pop_n = bus_pop_i ? OCC_W'(bus_nbytes_i) : '0;

  // Packet get only if a byte is left after the bus pop
  assign get_en = get_tx_packet_data_i && (count_q > pop_n);
  assign get_ptr = rd_ptr_q + PTR_W'(pop_n);
  assign rd_n = pop_n + OCC_W'(get_en);

  // **********************************************************
  // Storage
  // **********************************************************
  always_ff @(posedge tb_clk) begin
    if (!clear_i) begin
      if (store_rx_packet_data_i) begin
        mem[wr_ptr_q] <= rx_packet_data_i;
      end else if (push_en) begin
        // Least significant byte goes in first
        for (int i = 0; i < BUS_BYTES; i++) begin
          if (i < bus_nbytes_i) begin
            mem[wr_ptr_q + PTR_W'(i)] <= bus_push_data_i[i*BYTE_W +: BYTE_W];
          end
        end
      end
    end
  end

  // **********************************************************
  // Pointers and count
  // **********************************************************
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
      tx_data_q <= '0;
    end else if (clear_i) begin
      // Clear beats every other request
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(wr_n);
      rd_ptr_q <= rd_ptr_q + PTR_W'(rd_n);
      count_q <= count_q + wr_n - rd_n;
      if (get_en) begin
        tx_data_q <= mem[get_ptr];
      end
    end
  end

  // **********************************************************
  // Outputs
  // **********************************************************
  // First popped byte lands in bits 7:0, unused lanes zero
  always_comb begin
    bus_pop_data_o = '0;
    for (int i = 0; i < BUS_BYTES; i++) begin
      if (i < bus_nbytes_i) begin
        bus_pop_data_o[i*BYTE_W +: BYTE_W] = mem[rd_ptr_q + PTR_W'(i)];
      end
    end
  end

  assign occupancy_o = count_q;
  assign tx_packet_data_o = tx_data_q;

endmodule

/* logic/ahb_buffer.sv */
// Endpoint data buffer top level
`timescale 1ns/100ps

module ahb_buffer (
  input  logic                           tb_clk,
  input  logic                           rst_i,
  // AHB-Lite slave
  input  logic                           hsel_i,
  input  logic [ahb_buf_pkg::ADDR_W-1:0] haddr_i,
  input  ahb_buf_pkg::htrans_e           htrans_i,
  input  ahb_buf_pkg::hsize_e            hsize_i,
  input  logic                           hwrite_i,
  input  logic [ahb_buf_pkg::DATA_W-1:0] hwdata_i,
  output logic [ahb_buf_pkg::DATA_W-1:0] hrdata_o,
  output logic                           hresp_o,
  output logic                           hready_o,
  // Protocol controller
  input  logic                           rx_data_ready_i,
  input  logic                           rx_transfer_active_i,
  input  logic                           rx_error_i,
  input  logic                           tx_transfer_active_i,
  input  logic                           tx_error_i,
  input  logic                           clear_i,
  input  logic                           store_rx_packet_data_i,
  input  logic [ahb_buf_pkg::BYTE_W-1:0] rx_packet_data_i,
  input  logic                           get_tx_packet_data_i,
  output logic                           buffer_reserved_o,
  output logic [ahb_buf_pkg::OCC_W-1:0]  buffer_occupancy_o,
  output logic [ahb_buf_pkg::OCC_W-1:0]  tx_packet_data_size_o,
  output logic [ahb_buf_pkg::BYTE_W-1:0] tx_packet_data_o
);
  import ahb_buf_pkg::*;

  // Bus port to FIFO
  logic              bus_push;
  logic              bus_pop;
  logic [NB_W-1:0]   bus_nbytes;
  logic [DATA_W-1:0] bus_push_data;
  logic [DATA_W-1:0] bus_pop_data;
  logic              bus_push_stall;
  // Bus port to registers
  logic              reg_wr;
  logic [OCC_W-1:0]  reg_wdata;
  logic [DATA_W-1:0] status_word;

  // **********************************************************
  // Blocks
  // **********************************************************
  ahb_slave_port i_port (
    .tb_clk, .rst_i, .hsel_i, .haddr_i, .htrans_i, .hsize_i, .hwrite_i, .hwdata_i,
    .hrdata_o, .hresp_o, .hready_o,
    .occupancy_i(buffer_occupancy_o), .bus_push_stall_i(bus_push_stall),
    .bus_pop_data_i(bus_pop_data), .status_word_i(status_word),
    .tx_size_i(tx_packet_data_size_o), .bus_push_o(bus_push), .bus_pop_o(bus_pop),
    .bus_nbytes_o(bus_nbytes), .bus_push_data_o(bus_push_data),
    .reg_wr_o(reg_wr), .reg_wdata_o(reg_wdata)
  );

  endpoint_regs i_regs (
    .tb_clk, .rst_i, .rx_data_ready_i, .rx_transfer_active_i, .rx_error_i,
    .tx_transfer_active_i, .tx_error_i, .reg_wr_i(reg_wr), .reg_wdata_i(reg_wdata),
    .occupancy_i(buffer_occupancy_o), .status_word_o(status_word),
    .tx_size_o(tx_packet_data_size_o), .buffer_reserved_o
  );

  packet_fifo i_fifo (
    .tb_clk, .rst_i, .clear_i, .store_rx_packet_data_i, .rx_packet_data_i,
    .get_tx_packet_data_i, .bus_push_i(bus_push), .bus_pop_i(bus_pop),
    .bus_nbytes_i(bus_nbytes), .bus_push_data_i(bus_push_data),
    .occupancy_o(buffer_occupancy_o), .bus_pop_data_o(bus_pop_data),
    .bus_push_stall_o(bus_push_stall), .tx_packet_data_o
  );

endmodule

/* verif/tb_ahb_buffer_sva.sv */
// AHB response assertions
`timescale 1ns/100ps

module tb_ahb_buffer_sva (
  input logic tb_clk,
  input logic rst_i,
  input logic hresp_i,
  input logic hready_i
);

  // The two cycles of an ERROR response
  logic err_first;
  logic err_second;

  assign err_first = hresp_i && !hready_i;
  assign err_second = hresp_i && hready_i;

  // **********************************************************
  // Response checks
  // **********************************************************
  // Second ERROR cycle right after the first
  assert property (@(posedge tb_clk) disable iff (rst_i) err_first |=> err_second)
    else $error("ERROR response lost its second cycle");

  // hresp with hready only to close an ERROR
  assert property (@(posedge tb_clk) disable iff (rst_i) err_second |-> $past(err_first))
    else $error("hresp_o high with hready_o outside an ERROR response");

  // Bus ready once reset has been applied
  assert property (@(posedge tb_clk) rst_i |=> hready_i)
    else $error("hready_o low after reset");

endmodule

bind ahb_slave_port tb_ahb_buffer_sva i_sva (
  .tb_clk,
  .rst_i,
  .hresp_i(hresp_o),
  .hready_i(hready_o)
);

/* verif/tb_ahb_buffer.sv */
// Endpoint buffer testbench
`timescale 1ns/100ps

module tb_ahb_buffer;
  import ahb_buf_pkg::*;

  // Bus transfer as the master issues it
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic [DATA_W-1:0] wdata;
  } xfer_t;

  // Cycles allowed with hready_o low
  localparam int BUS_TIMEOUT = 16;

  logic              tb_clk;
  logic              rst_i;
  logic              hsel_i;
  logic [ADDR_W-1:0] haddr_i;
  htrans_e           htrans_i;
  hsize_e            hsize_i;
  logic              hwrite_i;
  logic [DATA_W-1:0] hwdata_i;
  logic [DATA_W-1:0] hrdata_o;
  logic              hresp_o;
  logic              hready_o;
  logic              rx_data_ready_i;
  logic              rx_transfer_active_i;
  logic              rx_error_i;
  logic              tx_transfer_active_i;
  logic              tx_error_i;
  logic              clear_i;
  logic              store_rx_packet_data_i;
  logic [BYTE_W-1:0] rx_packet_data_i;
  logic              get_tx_packet_data_i;
  logic              buffer_reserved_o;
  logic [OCC_W-1:0]  buffer_occupancy_o;
  logic [OCC_W-1:0]  tx_packet_data_size_o;
  logic [BYTE_W-1:0] tx_packet_data_o;

  integer            seed;
  // Transfers waiting to issue and transfers completed on the bus
  xfer_t             pend_q[$];
  xfer_t             done_x[$];
  logic [DATA_W-1:0] done_rdata[$];
  logic              done_resp[$];
  logic [OCC_W-1:0]  done_occ[$];
  // Reference state
  logic [BYTE_W-1:0] ref_q[$];
  logic [OCC_W-1:0]  ref_size;
  logic [STAT_W-1:0] ref_status;
  int                last_exp_occ;

  ahb_buffer i_dut (.*);

  initial tb_clk = 1'b0;
  always #2 tb_clk = ~tb_clk;

  // **********************************************************
  // Reference model
  // **********************************************************
  function automatic int nbytes_of(input logic [2:0] size);
    return (size == BYTE) ? 1 : ((size == HALF) ? 2 : 4);
  endfunction

  // Applies one transfer to the byte queue and registers
  function automatic void ref_transfer(input xfer_t x, output logic [DATA_W-1:0] rdata,
                                       output logic resp, output int occ);
    int nb;
    int i;
    nb = nbytes_of(x.size);
    rdata = '0;
    resp = 1'b0;
    if (x.addr >= ADDR_END) begin
      resp = 1'b1;
    end else if (x.addr <= ADDR_DATA_LAST) begin
      // Whole data window is one FIFO port
      if (x.write && nb > FIFO_DEPTH - ref_q.size()) begin
        resp = 1'b1;
      end else if (x.write) begin
        for (i = 0; i < nb; i++) ref_q.push_back(x.wdata[i*BYTE_W +: BYTE_W]);
      end else if (nb > ref_q.size()) begin
        resp = 1'b1;
      end else begin
        for (i = 0; i < nb; i++) rdata[i*BYTE_W +: BYTE_W] = ref_q.pop_front();
      end
    end else if (x.addr >= ADDR_TX_SIZE) begin
      if (x.write) ref_size = x.wdata[OCC_W-1:0];
      rdata = DATA_W'(ref_size);
    end else if (x.write) begin
      // Status and occupancy are read-only
      resp = 1'b1;
    end else if (x.addr >= ADDR_OCC) begin
      rdata = DATA_W'(ref_q.size());
    end else begin
      rdata = DATA_W'(ref_status);
    end
    occ = ref_q.size();
  endfunction

  // **********************************************************
  // Checks
  // **********************************************************
  task automatic compare_values(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  task automatic report_hang(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped after timeout");
  endtask

  // Packet-side outputs against the reference
  task automatic check_side_outputs();
    compare_values(buffer_occupancy_o, ref_q.size(), "buffer_occupancy_o");
    compare_values(tx_packet_data_size_o, ref_size, "tx_packet_data_size_o");
    compare_values(buffer_reserved_o, (ref_size != 0) && (ref_q.size() < ref_size),
                   "buffer_reserved_o");
  endtask

  // Checks every completed data phase one cycle after its sample
  always @(posedge tb_clk) begin : compare_bus
    xfer_t             x;
    logic [DATA_W-1:0] got_rdata;
    logic              got_resp;
    logic [OCC_W-1:0]  got_occ;
    logic [DATA_W-1:0] exp_rdata;
    logic [DATA_W-1:0] mask;
    logic              exp_resp;
    int                exp_occ;
    while (done_x.size() != 0) begin
      x = done_x.pop_front();
      got_rdata = done_rdata.pop_front();
      got_resp = done_resp.pop_front();
      got_occ = done_occ.pop_front();
      compare_values(got_occ, ref_q.size(), "occupancy before transfer");
      ref_transfer(x, exp_rdata, exp_resp, exp_occ);
      compare_values(got_resp, exp_resp, "hresp_o");
      // Only the transferred byte lanes of the data window
      mask = '1;
      if (x.addr <= ADDR_DATA_LAST) mask = (DATA_W'(1) << (8 * nbytes_of(x.size))) - 1;
      if (!exp_resp && !x.write) begin
        compare_values(got_rdata & mask, exp_rdata & mask, "hrdata_o");
      end
      last_exp_occ = exp_occ;
    end
  end

  // **********************************************************
  // Bus master
  // **********************************************************
  function automatic void add_xfer(input logic write, input logic [ADDR_W-1:0] addr,
                                   input hsize_e size, input logic [DATA_W-1:0] wdata);
    pend_q.push_back({write, addr, 3'(size), wdata});
  endfunction

  // Issues pend_q with overlapped address and data phases
  task automatic run_bus();
    xfer_t ap;
    xfer_t dp;
    logic  ap_valid;
    logic  dp_valid;
    logic  first;
    int    waited;
    ap_valid = 1'b0;
    dp_valid = 1'b0;
    first = 1'b1;
    waited = 0;
    do begin
      @(posedge tb_clk);
      if (!ap_valid && pend_q.size() != 0) begin
        ap = pend_q.pop_front();
        ap_valid = 1'b1;
        hsel_i <= 1'b1;
        haddr_i <= ap.addr;
        htrans_i <= first ? NONSEQ : SEQ;
        hsize_i <= hsize_e'(ap.size);
        hwrite_i <= ap.write;
        first = 1'b0;
      end else if (!ap_valid) begin
        hsel_i <= 1'b0;
        htrans_i <= IDLE;
      end
      // Held over wait states
      if (dp_valid) hwdata_i <= dp.wdata;
      @(negedge tb_clk);
      if (hready_o) begin
        if (dp_valid) begin
          done_x.push_back(dp);
          done_rdata.push_back(hrdata_o);
          done_resp.push_back(hresp_o);
          done_occ.push_back(buffer_occupancy_o);
        end
        dp = ap;
        dp_valid = ap_valid;
        ap_valid = 1'b0;
        waited = 0;
      end else begin
        waited++;
        if (waited > BUS_TIMEOUT) report_hang("bus hung with hready_o low");
      end
    end while (ap_valid || dp_valid || pend_q.size() != 0);
  endtask

  // Runs the queued transfers and lets the comparer catch up
  task automatic finish_run();
    int waited;
    run_bus();
    waited = 0;
    do begin
      @(negedge tb_clk);
      waited++;
      if (waited > BUS_TIMEOUT) report_hang("completed transfers never compared");
    end while (done_x.size() != 0);
    compare_values(buffer_occupancy_o, last_exp_occ, "occupancy after run");
    check_side_outputs();
  endtask

  // **********************************************************
  // Packet side
  // **********************************************************
  task automatic store_bytes(input int n);
    logic [BYTE_W-1:0] b;
    int                i;
    for (i = 0; i < n; i++) begin
      b = BYTE_W'($random(seed));
      @(posedge tb_clk);
      store_rx_packet_data_i <= 1'b1;
      rx_packet_data_i <= b;
      ref_q.push_back(b);
    end
    @(posedge tb_clk);
    store_rx_packet_data_i <= 1'b0;
    @(negedge tb_clk);
    check_side_outputs();
  endtask

  // One get pulse and the byte shows a cycle later
  task automatic get_byte();
    logic [BYTE_W-1:0] exp_b;
    exp_b = ref_q.pop_front();
    @(posedge tb_clk);
    get_tx_packet_data_i <= 1'b1;
    @(posedge tb_clk);
    get_tx_packet_data_i <= 1'b0;
    @(negedge tb_clk);
    compare_values(tx_packet_data_o, exp_b, "tx_packet_data_o");
    check_side_outputs();
  endtask

  task automatic drive_status();
    logic [STAT_W-1:0] s;
    s = STAT_W'($random(seed));
    @(posedge tb_clk);
    rx_data_ready_i <= s[0];
    rx_transfer_active_i <= s[1];
    rx_error_i <= s[2];
    tx_transfer_active_i <= s[3];
    tx_error_i <= s[4];
    ref_status = s;
  endtask

  // **********************************************************
  // Stimulus
  // **********************************************************
  initial begin
    int n;
    int i;
    seed = 32'he634;
    rst_i = 1'b1;
    hsel_i = 1'b0;
    haddr_i = '0;
    htrans_i = IDLE;
    hsize_i = WORD;
    hwrite_i = 1'b0;
    hwdata_i = '0;
    rx_data_ready_i = 1'b0;
    rx_transfer_active_i = 1'b0;
    rx_error_i = 1'b0;
    tx_transfer_active_i = 1'b0;
    tx_error_i = 1'b0;
    clear_i = 1'b0;
    store_rx_packet_data_i = 1'b0;
    rx_packet_data_i = '0;
    get_tx_packet_data_i = 1'b0;
    ref_size = '0;
    ref_status = '0;
    last_exp_occ = 0;
    repeat (4) @(posedge tb_clk);
    rst_i <= 1'b0;
    @(negedge tb_clk);
    compare_values(hready_o, 1'b1, "hready_o after reset");
    compare_values(tx_packet_data_o, '0, "tx_packet_data_o after reset");
    check_side_outputs();

    // Packet bytes read back over the bus
    store_bytes(8);
    add_xfer(1'b0, ADDR_OCC, WORD, '0);
    add_xfer(1'b0, 7'd0, WORD, '0);
    add_xfer(1'b0, 7'd4, HALF, '0);
    add_xfer(1'b0, 7'd6, HALF, '0);
    finish_run();

    // Host fills a two-byte packet
    add_xfer(1'b1, ADDR_TX_SIZE, WORD, 32'd2);
    finish_run();
    add_xfer(1'b1, 7'd0, HALF, 32'h0000abcd);
    finish_run();
    get_byte();
    get_byte();

    // Write runs then read runs with a hazard wait on the turn
    for (n = 4; n <= 16; n = n * 2) begin
      for (i = 0; i < n; i++) add_xfer(1'b1, ADDR_W'(4 * i), WORD, $random(seed));
      for (i = 0; i < n; i++) add_xfer(1'b0, ADDR_W'(4 * i), WORD, '0);
      finish_run();
    end

    // Illegal accesses
    add_xfer(1'b1, ADDR_STATUS, WORD, 32'h1f);
    add_xfer(1'b0, 7'd80, WORD, '0);
    add_xfer(1'b0, 7'd0, WORD, '0);
    finish_run();
    // Overfill then overread
    for (i = 0; i <= 16; i++) add_xfer(1'b1, ADDR_W'((4 * i) % 64), WORD, $random(seed));
    for (i = 0; i <= 16; i++) add_xfer(1'b0, ADDR_W'((4 * i) % 64), WORD, '0);
    finish_run();

    // Status flags and clear
    for (i = 0; i < 2; i++) begin
      drive_status();
      add_xfer(1'b0, ADDR_STATUS, WORD, '0);
      finish_run();
    end
    store_bytes(5);
    @(posedge tb_clk);
    clear_i <= 1'b1;
    @(posedge tb_clk);
    clear_i <= 1'b0;
    ref_q.delete();
    @(negedge tb_clk);
    check_side_outputs();
    add_xfer(1'b0, ADDR_OCC, WORD, '0);
    finish_run();

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* verilog.f */
logic/ahb_buf_pkg.sv
logic/ahb_slave_port.sv
logic/endpoint_regs.sv
logic/packet_fifo.sv
logic/ahb_buffer.sv
verif/tb_ahb_buffer_sva.sv
verif/tb_ahb_buffer.sv

/* Bender.yml */
package:
  name: ahb_buffer

sources:
  # Package first, then the blocks, then the top level
  - logic/ahb_buf_pkg.sv
  - logic/ahb_slave_port.sv
  - logic/endpoint_regs.sv
  - logic/packet_fifo.sv
  - logic/ahb_buffer.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - verif/tb_ahb_buffer_sva.sv
      - verif/tb_ahb_buffer.sv
